// File: mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// bus widths
`define MEM_ADDR_W        32
`define MEM_DATA_W        32
`define MEM_STRB_W        4

// icache geometry, 256 lines of 16 bytes
`define MEM_LINE_WORDS    4     // also the refill burst length
`define MEM_INDEX_W       8
`define MEM_OFFSET_W      4
`define MEM_TAG_W         20

// axi ids and field widths
`define MEM_AXI_ID_W      4
`define MEM_AXI_LEN_W     8
`define MEM_INST_ID       4'd0
`define MEM_DATA_ID       4'd1
`define MEM_AXI_SIZE_WORD 3'd2

// attributes the subsystem never varies
`define MEM_AXI_ATTR_CACHE 4'b0000
`define MEM_AXI_ATTR_PROT  3'b000

`endif

// File: mem_pkg.sv
`default_nettype none
`include "mem_settings.svh"

package mem_pkg;

    // sram-style request, same layout on fetch and data ports
    typedef struct packed {
        logic                   req;
        logic                   wr;
        logic [1:0]             size;   // 0 byte, 1 half, 2 word
        logic [`MEM_STRB_W-1:0] wstrb;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                   rd_req;
        logic [`MEM_ADDR_W-1:0] rd_addr;  // line aligned
    } refill_req_t;

    typedef struct packed {
        logic                   ret_valid;
        logic                   ret_last;
        logic [`MEM_DATA_W-1:0] ret_data;
    } refill_ret_t;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    typedef struct packed {
        logic [`MEM_AXI_ID_W-1:0]  arid;
        logic [`MEM_ADDR_W-1:0]    araddr;
        logic [`MEM_AXI_LEN_W-1:0] arlen;
        logic [2:0]                arsize;
        axi_burst_e                arburst;
        logic [1:0]                arlock;
        logic [3:0]                arcache;
        logic [2:0]                arprot;
        logic                      arvalid;
    } axi_ar_t;

    typedef struct packed {
        logic [`MEM_AXI_ID_W-1:0] rid;
        logic [`MEM_DATA_W-1:0]   rdata;
        logic [1:0]               rresp;
        logic                     rlast;
        logic                     rvalid;
    } axi_r_t;

    typedef struct packed {
        logic [`MEM_AXI_ID_W-1:0]  awid;
        logic [`MEM_ADDR_W-1:0]    awaddr;
        logic [`MEM_AXI_LEN_W-1:0] awlen;
        logic [2:0]                awsize;
        axi_burst_e                awburst;
        logic [1:0]                awlock;
        logic [3:0]                awcache;
        logic [2:0]                awprot;
        logic                      awvalid;
    } axi_aw_t;

    typedef struct packed {
        logic [`MEM_AXI_ID_W-1:0] wid;
        logic [`MEM_DATA_W-1:0]   wdata;
        logic [`MEM_STRB_W-1:0]   wstrb;
        logic                     wlast;
        logic                     wvalid;
    } axi_w_t;

    typedef struct packed {
        logic [`MEM_AXI_ID_W-1:0] bid;
        logic [1:0]               bresp;
        logic                     bvalid;
    } axi_b_t;

    typedef enum logic [1:0] {
        ic_idle,
        ic_lookup,
        ic_miss,
        ic_refill
    } icache_state_e;

    // shared by the ar and the aw/w/b machines
    typedef enum logic [1:0] {
        br_idle,
        br_addr,    // address (and write data) waiting for ready
        br_resp     // write sent, waiting for b
    } bridge_state_e;

endpackage

`default_nettype wire

// File: icache.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module icache
    import mem_pkg::*;
(
    input  wire                    aclk,
    input  wire                    reset,
    input  wire cpu_req_t          inst_req,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [`MEM_DATA_W-1:0] rdata,
    output refill_req_t            refill_req,
    input  wire                    rd_rdy,
    input  wire refill_ret_t       refill_ret
);

    localparam int LINES  = 1 << `MEM_INDEX_W;
    localparam int LINE_W = `MEM_LINE_WORDS * `MEM_DATA_W;
    localparam int WORD_W = `MEM_OFFSET_W - 2;

    icache_state_e state;
    icache_state_e state_nxt;

    logic [LINE_W-1:0]      line_mem [LINES];
    logic [`MEM_TAG_W-1:0]  tag_mem  [LINES];
    logic [LINES-1:0]       valid_q;

    logic [`MEM_ADDR_W-1:0]  addr_q;     // address of the request in lookup
    logic [`MEM_TAG_W-1:0]   tag_q;
    logic [`MEM_INDEX_W-1:0] index_q;
    logic [WORD_W-1:0]       word_q;
    logic [WORD_W-1:0]       beat_cnt;
    logic                    hit;
    logic                    beat_fire;
    logic                    last_fire;
    logic                    pending_q;

    assign tag_q   = addr_q[`MEM_ADDR_W-1 -: `MEM_TAG_W];
    assign index_q = addr_q[`MEM_OFFSET_W +: `MEM_INDEX_W];
    assign word_q  = addr_q[`MEM_OFFSET_W-1:2];

    assign hit = (state == ic_lookup) && valid_q[index_q] && (tag_mem[index_q] == tag_q);

    assign beat_fire = (state == ic_refill) && refill_ret.ret_valid;
    assign last_fire = beat_fire && refill_ret.ret_last;

    // accept in idle, or back to back behind a hit
    assign addr_ok = inst_req.req && ((state == ic_idle) || hit);
    assign data_ok = hit;
    assign rdata   = line_mem[index_q][word_q*`MEM_DATA_W +: `MEM_DATA_W];

    always_comb begin
        refill_req.rd_req  = (state == ic_miss);
        refill_req.rd_addr = {addr_q[`MEM_ADDR_W-1:`MEM_OFFSET_W], {`MEM_OFFSET_W{1'b0}}};
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ic_idle: begin
                if (inst_req.req)
                    state_nxt = ic_lookup;
            end
            ic_lookup: begin
                if (!hit)
                    state_nxt = ic_miss;
                else if (!inst_req.req)
                    state_nxt = ic_idle;
            end
            ic_miss: begin
                if (rd_rdy)
                    state_nxt = ic_refill;
            end
            ic_refill: begin
                // re-run lookup, which now hits
                if (last_fire)
                    state_nxt = ic_lookup;
            end
            default: state_nxt = ic_idle;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset)
            state <= ic_idle;
        else
            state <= state_nxt;
    end

    always_ff @(posedge aclk) begin
        if (addr_ok)
            addr_q <= inst_req.addr;
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (state == ic_miss) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            beat_cnt <= beat_cnt + 1'b1;   // beats arrive in address order
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_fire)
            line_mem[index_q][beat_cnt*`MEM_DATA_W +: `MEM_DATA_W] <= refill_ret.ret_data;
        if (last_fire)
            tag_mem[index_q] <= tag_q;
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (state == ic_miss && rd_rdy) begin
            valid_q[index_q] <= 1'b0;    // line is half old, half new until last beat
        end else if (last_fire) begin
            valid_q[index_q] <= 1'b1;
        end
    end

    // one request in flight at a time
    always_ff @(posedge aclk) begin
        if (reset)
            pending_q <= 1'b0;
        else if (addr_ok)
            pending_q <= 1'b1;
        else if (data_ok)
            pending_q <= 1'b0;
    end

    a_no_write: assert property (@(posedge aclk) disable iff (reset)
        inst_req.req |-> !inst_req.wr)
        else $error("write request on fetch port");

    a_data_ok_owed: assert property (@(posedge aclk) disable iff (reset)
        data_ok |-> pending_q)
        else $error("data_ok without an accepted fetch");

    a_refill_hold: assert property (@(posedge aclk) disable iff (reset)
        refill_req.rd_req && !rd_rdy |=> refill_req.rd_req && $stable(refill_req.rd_addr))
        else $error("refill request dropped or changed before rd_rdy");

endmodule

`default_nettype wire

// File: bridge_sram_axi.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module bridge_sram_axi
    import mem_pkg::*;
(
    input  wire                    aclk,
    input  wire                    reset,
    // icache refill side
    input  wire refill_req_t       refill_req,
    output logic                   rd_rdy,
    output refill_ret_t            refill_ret,
    // data port
    input  wire cpu_req_t          data_req,
    output logic                   data_addr_ok,
    output logic                   data_data_ok,
    output logic [`MEM_DATA_W-1:0] data_rdata,
    // axi master
    output axi_ar_t                ar,
    input  wire                    arready,
    input  wire axi_r_t            r,
    output logic                   rready,
    output axi_aw_t                aw,
    input  wire                    awready,
    output axi_w_t                 w,
    input  wire                    wready,
    input  wire axi_b_t            b,
    output logic                   bready
);

    bridge_state_e rd_state;
    bridge_state_e wr_state;

    axi_ar_t ar_pld;
    axi_aw_t aw_pld;
    axi_w_t  w_pld;

    logic inst_rd_busy;   // refill burst in flight
    logic data_rd_busy;   // single data read in flight
    logic data_busy;
    logic aw_pend;
    logic w_pend;
    logic data_rd_take;
    logic wr_take;
    logic r_inst_fire;
    logic r_data_fire;
    logic b_fire;

    assign data_busy = data_rd_busy || (wr_state != br_idle);

    // refill has priority on ar
    assign rd_rdy       = refill_req.rd_req && (rd_state == br_idle) && !inst_rd_busy;
    assign data_rd_take = data_req.req && !data_req.wr && (rd_state == br_idle)
                          && !rd_rdy && !data_busy;
    assign wr_take      = data_req.req && data_req.wr && !data_busy;
    assign data_addr_ok = data_rd_take || wr_take;

    assign rready      = inst_rd_busy || data_rd_busy;
    assign bready      = (wr_state != br_idle);
    assign r_inst_fire = r.rvalid && rready && (r.rid == `MEM_INST_ID);
    assign r_data_fire = r.rvalid && rready && (r.rid == `MEM_DATA_ID);
    assign b_fire      = b.bvalid && bready && (wr_state == br_resp) && (b.bid == `MEM_DATA_ID);

    always_comb begin
        ar         = ar_pld;
        ar.arvalid = ar_pld.arvalid && (rd_state == br_addr);
        aw         = aw_pld;
        aw.awvalid = aw_pld.awvalid && aw_pend;
        w          = w_pld;
        w.wvalid   = w_pld.wvalid && w_pend;
    end

    // refill beats pass straight through, icache always takes them
    always_comb begin
        refill_ret.ret_valid = r_inst_fire && inst_rd_busy;
        refill_ret.ret_last  = r.rlast;
        refill_ret.ret_data  = r.rdata;
    end

    always_ff @(posedge aclk) begin
        if (rd_rdy) begin
            ar_pld.arid    <= `MEM_INST_ID;
            ar_pld.araddr  <= refill_req.rd_addr;
            ar_pld.arlen   <= `MEM_AXI_LEN_W'(`MEM_LINE_WORDS - 1);
            ar_pld.arsize  <= `MEM_AXI_SIZE_WORD;
            ar_pld.arburst <= burst_incr;
        end else if (data_rd_take) begin
            ar_pld.arid    <= `MEM_DATA_ID;
            ar_pld.araddr  <= data_req.addr;
            ar_pld.arlen   <= '0;                   // single beat
            ar_pld.arsize  <= {1'b0, data_req.size};
            ar_pld.arburst <= burst_incr;
        end
        ar_pld.arlock  <= 2'b00;
        ar_pld.arcache <= `MEM_AXI_ATTR_CACHE;
        ar_pld.arprot  <= `MEM_AXI_ATTR_PROT;
        ar_pld.arvalid <= 1'b1;
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            rd_state <= br_idle;
        end else begin
            case (rd_state)
                br_idle: if (rd_rdy || data_rd_take) rd_state <= br_addr;
                br_addr: if (arready) rd_state <= br_idle;
                default: rd_state <= br_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            inst_rd_busy <= 1'b0;
            data_rd_busy <= 1'b0;
        end else begin
            if (rd_rdy)
                inst_rd_busy <= 1'b1;
            else if (r_inst_fire && r.rlast)
                inst_rd_busy <= 1'b0;
            if (data_rd_take)
                data_rd_busy <= 1'b1;
            else if (r_data_fire)
                data_rd_busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_take) begin
            aw_pld.awid    <= `MEM_DATA_ID;
            aw_pld.awaddr  <= data_req.addr;
            aw_pld.awlen   <= '0;
            aw_pld.awsize  <= {1'b0, data_req.size};
            aw_pld.awburst <= burst_incr;
            w_pld.wdata    <= data_req.wdata;
            w_pld.wstrb    <= data_req.wstrb;
        end
        aw_pld.awlock  <= 2'b00;
        aw_pld.awcache <= `MEM_AXI_ATTR_CACHE;
        aw_pld.awprot  <= `MEM_AXI_ATTR_PROT;
        aw_pld.awvalid <= 1'b1;
        w_pld.wid      <= `MEM_DATA_ID;
        w_pld.wlast    <= 1'b1;
        w_pld.wvalid   <= 1'b1;
    end

    // aw and w go out independently, b only after both
    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_state <= br_idle;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
        end else begin
            case (wr_state)
                br_idle: begin
                    if (wr_take) begin
                        wr_state <= br_addr;
                        aw_pend  <= 1'b1;
                        w_pend   <= 1'b1;
                    end
                end
                br_addr: begin
                    if (awready)
                        aw_pend <= 1'b0;
                    if (wready)
                        w_pend <= 1'b0;
                    if ((!aw_pend || awready) && (!w_pend || wready))
                        wr_state <= br_resp;
                end
                br_resp: if (b_fire) wr_state <= br_idle;
                default: wr_state <= br_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (reset)
            data_data_ok <= 1'b0;
        else
            data_data_ok <= r_data_fire || b_fire;
    end

    always_ff @(posedge aclk) begin
        if (r_data_fire)
            data_rdata <= r.rdata;
    end

    a_ar_hold: assert property (@(posedge aclk) disable iff (reset)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar))
        else $error("ar payload changed while waiting");

    a_aw_hold: assert property (@(posedge aclk) disable iff (reset)
        aw.awvalid && !awready |=> aw.awvalid && $stable(aw))
        else $error("aw payload changed while waiting");

    a_w_hold: assert property (@(posedge aclk) disable iff (reset)
        w.wvalid && !wready |=> w.wvalid && $stable(w))
        else $error("w payload changed while waiting");

    a_data_ok_owed: assert property (@(posedge aclk) disable iff (reset)
        data_data_ok |-> $past(data_busy))
        else $error("data_ok with no data transaction outstanding");

endmodule

`default_nettype wire

// File: mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module mem_subsys_top
    import mem_pkg::*;
(
    input  wire                    aclk,
    input  wire                    reset,
    // fetch port
    input  wire cpu_req_t          inst_req,
    output logic                   inst_addr_ok,
    output logic                   inst_data_ok,
    output logic [`MEM_DATA_W-1:0] inst_rdata,
    // data port
    input  wire cpu_req_t          data_req,
    output logic                   data_addr_ok,
    output logic                   data_data_ok,
    output logic [`MEM_DATA_W-1:0] data_rdata,
    // axi master
    output axi_ar_t                ar,
    input  wire                    arready,
    input  wire axi_r_t            r,
    output logic                   rready,
    output axi_aw_t                aw,
    input  wire                    awready,
    output axi_w_t                 w,
    input  wire                    wready,
    input  wire axi_b_t            b,
    output logic                   bready
);

    refill_req_t refill_req;   // icache line request
    refill_ret_t refill_ret;
    logic        rd_rdy;

    icache u_icache (
        .aclk       (aclk),
        .reset      (reset),
        .inst_req   (inst_req),
        .addr_ok    (inst_addr_ok),
        .data_ok    (inst_data_ok),
        .rdata      (inst_rdata),
        .refill_req (refill_req),
        .rd_rdy     (rd_rdy),
        .refill_ret (refill_ret)
    );

    bridge_sram_axi u_bridge (
        .aclk         (aclk),
        .reset        (reset),
        .refill_req   (refill_req),
        .rd_rdy       (rd_rdy),
        .refill_ret   (refill_ret),
        .data_req     (data_req),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .ar           (ar),
        .arready      (arready),
        .r            (r),
        .rready       (rready),
        .aw           (aw),
        .awready      (awready),
        .w            (w),
        .wready       (wready),
        .b            (b),
        .bready       (bready)
    );

endmodule

`default_nettype wire

// File: tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module tb_axi_mem
    import mem_pkg::*;
#(
    parameter logic [31:0] MIX  = 32'h5a17_c3e9,
    parameter integer      SEED = 96
) (
    input  wire          aclk,
    input  wire          reset,
    input  wire axi_ar_t ar,
    output logic         arready,
    output axi_r_t       r,
    input  wire          rready,
    input  wire axi_aw_t aw,
    output logic         awready,
    input  wire axi_w_t  w,
    output logic         wready,
    output axi_b_t       b,
    input  wire          bready
);

    integer  seed = SEED;
    axi_ar_t rd_q[$];     // accepted reads, served in order
    int      beat;
    axi_aw_t aw_hold;
    axi_w_t  w_hold;
    bit      aw_got;
    bit      w_got;

    // written words, slot picked by address bits 11:2
    logic [31:0] wr_mem  [1024];
    logic [31:0] wr_addr [1024];
    bit          wr_used [1024];

    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [9:0] slot;
        slot = a[11:2];
        if (wr_used[slot] && wr_addr[slot] == {a[31:2], 2'b00})
            return wr_mem[slot];
        return {a[31:2], 2'b00} * 32'h9e37_79b1 + MIX;
    endfunction

    initial begin
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        r       = '0;
        b       = '0;
    end

    always @(posedge aclk) begin : read_side
        axi_ar_t cur;
        if (reset) begin
            arready <= 1'b0;
            r       <= '0;
            rd_q.delete();
            beat = 0;
        end else begin
            if (ar.arvalid && arready)
                rd_q.push_back(ar);
            if (r.rvalid && rready) begin
                beat = beat + 1;
                if (r.rlast) begin
                    rd_q.delete(0);
                    beat = 0;
                end
            end
            arready <= ($random(seed) & 3) != 0;
            if (!r.rvalid || rready) begin   // a waiting beat is held as is
                r.rvalid <= 1'b0;
                if (rd_q.size() > 0 && ($random(seed) & 3) != 0) begin
                    cur = rd_q[0];
                    r.rid    <= cur.arid;
                    r.rdata  <= word_at(cur.araddr + 32'(beat * 4));
                    r.rresp  <= 2'b00;
                    r.rlast  <= (beat == int'(cur.arlen));
                    r.rvalid <= 1'b1;
                end
            end
        end
    end

    always @(posedge aclk) begin : write_side
        logic [9:0]  slot;
        logic [31:0] merged;
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            b       <= '0;
            aw_got = 1'b0;
            w_got  = 1'b0;
        end else begin
            if (aw.awvalid && awready) begin
                aw_hold = aw;
                aw_got  = 1'b1;
            end
            if (w.wvalid && wready) begin
                w_hold = w;
                w_got  = 1'b1;
            end
            awready <= ($random(seed) & 1) != 0;
            wready  <= ($random(seed) & 1) != 0;
            if (b.bvalid && bready) begin
                b.bvalid <= 1'b0;
            end else if (!b.bvalid && aw_got && w_got && (($random(seed) & 1) != 0)) begin
                merged = word_at(aw_hold.awaddr);
                for (int i = 0; i < 4; i++)
                    if (w_hold.wstrb[i])
                        merged[8*i +: 8] = w_hold.wdata[8*i +: 8];
                slot = aw_hold.awaddr[11:2];
                wr_mem[slot]  = merged;
                wr_addr[slot] = {aw_hold.awaddr[31:2], 2'b00};
                wr_used[slot] = 1'b1;
                b.bid    <= aw_hold.awid;
                b.bresp  <= 2'b00;
                b.bvalid <= 1'b1;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module tb_mem_subsys
    import mem_pkg::*;
();

    localparam logic [31:0] MIX       = 32'h5a17_c3e9;
    localparam logic [31:0] DATA_BASE = 32'h8000_0000;   // data region that fetches never touch
    localparam int          TIMEOUT   = 400;

    logic                   aclk;
    logic                   reset;
    cpu_req_t               inst_req;
    cpu_req_t               data_req;
    logic                   inst_addr_ok;
    logic                   inst_data_ok;
    logic [`MEM_DATA_W-1:0] inst_rdata;
    logic                   data_addr_ok;
    logic                   data_data_ok;
    logic [`MEM_DATA_W-1:0] data_rdata;
    axi_ar_t                ar;
    logic                   arready;
    axi_r_t                 r;
    logic                   rready;
    axi_aw_t                aw;
    logic                   awready;
    axi_w_t                 w;
    logic                   wready;
    axi_b_t                 b;
    logic                   bready;

    integer      seed;
    int          tests;
    int          checks;
    int          errors;
    int          burst_cnt;    // line refills seen on ar
    int          single_cnt;   // single data reads seen on ar
    int          inst_done;
    int          data_done;
    int          inst_sent;    // fetches accepted
    int          data_sent;    // data accesses accepted
    logic [31:0] shadow [256];
    bit          shadow_used [256];
    string       inst_name_q[$];
    logic [31:0] inst_exp_q[$];
    string       data_name_q[$];
    logic [31:0] data_exp_q[$];
    bit          data_wr_q[$];

    mem_subsys_top i_dut (
        .aclk(aclk), .reset(reset),
        .inst_req(inst_req), .inst_addr_ok(inst_addr_ok),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .data_req(data_req), .data_addr_ok(data_addr_ok),
        .data_data_ok(data_data_ok), .data_rdata(data_rdata),
        .ar(ar), .arready(arready), .r(r), .rready(rready),
        .aw(aw), .awready(awready), .w(w), .wready(wready),
        .b(b), .bready(bready)
    );

    tb_axi_mem #(.MIX(MIX), .SEED(96)) u_axi_mem (
        .aclk(aclk), .reset(reset),
        .ar(ar), .arready(arready), .r(r), .rready(rready),
        .aw(aw), .awready(awready), .w(w), .wready(wready),
        .b(b), .bready(bready)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // expected word is the address mixed with a constant unless a store touched it
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [31:0] wa;
        wa = {addr[31:2], 2'b00};
        if (wa[31:10] == DATA_BASE[31:10] && shadow_used[wa[9:2]])
            return shadow[wa[9:2]];
        return wa * 32'h9e37_79b1 + MIX;
    endfunction

    task automatic check_inst_word(input string name, input logic [`MEM_DATA_W-1:0] exp,
                                   input logic [`MEM_DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s fetch word: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_data_word(input string name, input logic [`MEM_DATA_W-1:0] exp,
                                   input logic [`MEM_DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s data word: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ar_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Error %s ar count: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("%-16s %s, %0d errors", name, (errors == errs_before) ? "ok" : "FAILED",
                 errors - errs_before);
    endtask

    task automatic fetch(input string name, input logic [31:0] addr);
        int target;
        int cnt;
        target = inst_done + 1;
        cnt    = 0;
        @(posedge aclk);
        inst_req.req  <= 1'b1;
        inst_req.wr   <= 1'b0;
        inst_req.size <= 2'd2;
        inst_req.addr <= addr;
        @(negedge aclk);
        while (!inst_addr_ok) begin
            cnt++;
            if (cnt > TIMEOUT)
                abort_run({"fetch never accepted in ", name});
            @(negedge aclk);
        end
        inst_name_q.push_back(name);
        inst_exp_q.push_back(ref_word(addr));
        inst_sent++;
        @(posedge aclk);
        inst_req.req <= 1'b0;
        cnt = 0;
        while (inst_done < target) begin
            cnt++;
            if (cnt > TIMEOUT)
                abort_run({"fetch never answered in ", name});
            @(negedge aclk);
        end
    endtask

    task automatic data_access(input string name, input bit wr, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb);
        int          target;
        int          cnt;
        logic [31:0] merged;
        target = data_done + 1;
        cnt    = 0;
        @(posedge aclk);
        data_req.req   <= 1'b1;
        data_req.wr    <= wr;
        data_req.size  <= 2'd2;
        data_req.wstrb <= strb;
        data_req.addr  <= addr;
        data_req.wdata <= wdata;
        @(negedge aclk);
        while (!data_addr_ok) begin
            cnt++;
            if (cnt > TIMEOUT)
                abort_run({"data access never accepted in ", name});
            @(negedge aclk);
        end
        if (wr) begin
            merged = ref_word(addr);
            for (int i = 0; i < 4; i++)
                if (strb[i])
                    merged[8*i +: 8] = wdata[8*i +: 8];
            shadow[addr[9:2]]      = merged;
            shadow_used[addr[9:2]] = 1'b1;
        end
        data_name_q.push_back(name);
        data_exp_q.push_back(ref_word(addr));
        data_wr_q.push_back(wr);
        data_sent++;
        @(posedge aclk);
        data_req.req <= 1'b0;
        cnt = 0;
        while (data_done < target) begin
            cnt++;
            if (cnt > TIMEOUT)
                abort_run({"data access never answered in ", name});
            @(negedge aclk);
        end
    endtask

    // responses matched in order against what was accepted
    always @(negedge aclk) begin : compare
        string       name;
        logic [31:0] exp;
        if (!reset && inst_data_ok) begin
            if (inst_exp_q.size() == 0) begin
                errors++;
                $display("fetch data_ok arrived with no fetch outstanding");
            end else begin
                name = inst_name_q.pop_front();
                check_inst_word(name, inst_exp_q.pop_front(), inst_rdata);
            end
            inst_done++;
        end
        if (!reset && data_data_ok) begin
            if (data_exp_q.size() == 0) begin
                errors++;
                $display("data data_ok arrived with no data access outstanding");
            end else begin
                name = data_name_q.pop_front();
                exp  = data_exp_q.pop_front();
                if (!data_wr_q.pop_front())
                    check_data_word(name, exp, data_rdata);
            end
            data_done++;
        end
    end

    always @(negedge aclk) begin
        if (!reset && ar.arvalid && arready) begin   // handshake at the next edge
            if (ar.arid == `MEM_INST_ID && ar.arlen == 8'd3 && ar.arburst == burst_incr
                    && ar.arsize == 3'd2 && ar.araddr[3:0] == 4'h0) begin
                burst_cnt++;
            end else if (ar.arid == `MEM_DATA_ID && ar.arlen == 8'd0 && ar.arsize == 3'd2) begin
                single_cnt++;
            end else begin
                errors++;
                $display("ar handshake with unexpected fields at address %h", ar.araddr);
            end
        end
        if (!reset && aw.awvalid && awready && (aw.awid != `MEM_DATA_ID
                || aw.awlen != 8'd0 || aw.awsize != 3'd2 || aw.awburst != burst_incr)) begin
            errors++;
            $display("aw handshake with unexpected fields at address %h", aw.awaddr);
        end
        if (!reset && w.wvalid && wready && !w.wlast) begin
            errors++;
            $display("write data beat without wlast on a single-beat write");
        end
    end

    initial begin
        int          e0;
        int          b0;
        int          s0;
        seed     = 96;
        reset    = 1'b1;
        inst_req = '0;
        data_req = '0;
        repeat (3) @(posedge aclk);
        reset <= 1'b0;

        e0 = errors;
        b0 = burst_cnt;
        fetch("fetch_miss_hit", 32'h0000_1230);
        check_ar_count("fetch_miss_hit", b0 + 1, burst_cnt);
        fetch("fetch_miss_hit", 32'h0000_1230);
        check_ar_count("fetch_miss_hit", b0 + 1, burst_cnt);
        end_test("fetch_miss_hit", e0);

        e0 = errors;
        fetch("same_line", 32'h0000_1234);
        fetch("same_line", 32'h0000_1238);
        fetch("same_line", 32'h0000_123c);
        check_ar_count("same_line", b0 + 1, burst_cnt);
        end_test("same_line", e0);

        // same index 0x45 with different tags
        e0 = errors;
        b0 = burst_cnt;
        fetch("conflict", 32'h0000_2454);
        fetch("conflict", 32'h0004_2458);
        fetch("conflict", 32'h0000_2454);
        fetch("conflict", 32'h0004_2458);
        check_ar_count("conflict", b0 + 4, burst_cnt);
        end_test("conflict", e0);

        e0 = errors;
        b0 = burst_cnt;
        s0 = single_cnt;
        data_access("data_read", 1'b0, DATA_BASE + 32'h100, '0, 4'h0);
        check_ar_count("data_read", s0 + 1, single_cnt);
        check_ar_count("data_read", b0, burst_cnt);
        end_test("data_read", e0);

        e0 = errors;
        s0 = single_cnt;
        data_access("write_read", 1'b1, DATA_BASE + 32'h200, 32'hdead_beef, 4'b0101);
        data_access("write_read", 1'b0, DATA_BASE + 32'h200, '0, 4'h0);
        check_ar_count("write_read", s0 + 1, single_cnt);
        end_test("write_read", e0);

        e0 = errors;
        fork
            begin : fetch_stream
                logic [31:0] fa;
                for (int i = 0; i < 40; i++) begin
                    fa = $random(seed) & 32'h0000_3ffc;   // four tags over every index
                    fetch("mixed_fetch", fa);
                end
            end
            begin : data_stream
                logic [31:0] da;
                logic [31:0] dw;
                logic [31:0] ds;
                for (int i = 0; i < 40; i++) begin
                    da = DATA_BASE | ($random(seed) & 32'h0000_00fc);
                    dw = $random(seed);
                    ds = $random(seed);
                    data_access("mixed_data", ds[4], da, dw, ds[3:0]);
                end
            end
        join
        if (inst_done != inst_sent || data_done != data_sent) begin
            errors++;
            $display("responses do not match accepted requests: fetch %0d of %0d, data %0d of %0d",
                     inst_done, inst_sent, data_done, data_sent);
        end
        end_test("mixed_traffic", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
mem_pkg.sv
icache.sv
bridge_sram_axi.sv
mem_subsys_top.sv
tb_axi_mem.sv
tb_mem_subsys.sv
